// File: common/rank_defs.svh
`ifndef RANK_DEFS_SVH
`define RANK_DEFS_SVH

// pixel width in bits
`define PIX_W 8

// cycles through one five-input sorter
`define SORT5_LAT 3

// cycles through the seven-input sorter
`define SORT7_LAT 10

`endif

// File: common/rank_pkg.sv
`default_nettype none
`include "rank_defs.svh"

package rank_pkg;

  typedef logic [`PIX_W-1:0] pix_t;

  // s1 of the sliding window holds the oldest sample
  typedef struct packed {
    pix_t s1;
    pix_t s2;
    pix_t s3;
    pix_t s4;
    pix_t s5;
    pix_t s6;
    pix_t s7;
  } win7_t;

  typedef struct packed {
    pix_t v1;
    pix_t v2;
    pix_t v3;
    pix_t v4;
    pix_t v5;
  } vec5_t;

  // r1 is the minimum, r7 the maximum
  typedef struct packed {
    pix_t r1;
    pix_t r2;
    pix_t r3;
    pix_t r4;
    pix_t r5;
    pix_t r6;
    pix_t r7;
  } sorted7_t;

  typedef enum logic [1:0] {
    RANK_MIN = 2'd0,
    RANK_MED = 2'd1,
    RANK_MAX = 2'd2
  } rank_mode_e;

endpackage

`default_nettype wire

// File: src/sort3_net.sv
`timescale 1ns/1ps
`default_nettype none

module sort3_net (
  input  logic [7:0] a_i,
  input  logic [7:0] b_i,
  input  logic [7:0] c_i,
  output logic [7:0] min_o,
  output logic [7:0] med_o,
  output logic [7:0] max_o
);

  logic [7:0] lo_ab;
  logic [7:0] hi_ab;
  logic [7:0] lo_hc;

  // order a and b
  assign lo_ab = (a_i < b_i) ? a_i : b_i;
  assign hi_ab = (a_i < b_i) ? b_i : a_i;

  // larger of the pair against c gives the maximum
  assign lo_hc = (hi_ab < c_i) ? hi_ab : c_i;
  assign max_o = (hi_ab < c_i) ? c_i : hi_ab;

  // the two leftovers give minimum and median
  assign min_o = (lo_ab < lo_hc) ? lo_ab : lo_hc;
  assign med_o = (lo_ab < lo_hc) ? lo_hc : lo_ab;

endmodule

`default_nettype wire

// File: sort5/sort5_pipe.sv
`timescale 1ns/1ps
`default_nettype none
`include "rank_defs.svh"

module sort5_pipe
  import rank_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n,
  input  logic  valid_i,
  input  vec5_t vec_i,
  output logic  valid_o,
  output vec5_t vec_o
);

  vec5_t                 s1_q;
  vec5_t                 s2_q;
  pix_t                  tri_min;
  pix_t                  tri_med;
  pix_t                  tri_max;
  pix_t                  mid_min;
  pix_t                  mid_med;
  pix_t                  mid_max;
  logic [`SORT5_LAT-1:0] valid_q;

  // first three inputs sorted as a triple
  sort3_net u_sort3_in (
    .a_i   (vec_i.v1),
    .b_i   (vec_i.v2),
    .c_i   (vec_i.v3),
    .min_o (tri_min),
    .med_o (tri_med),
    .max_o (tri_max)
  );

  // after the merge step only the middle three are still unordered
  sort3_net u_sort3_mid (
    .a_i   (s2_q.v2),
    .b_i   (s2_q.v3),
    .c_i   (s2_q.v4),
    .min_o (mid_min),
    .med_o (mid_med),
    .max_o (mid_max)
  );

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      s1_q    <= '0;
      s2_q    <= '0;
      vec_o   <= '0;
      valid_q <= '0;
    end else begin
      // triple in v1..v3, ordered pair in v4..v5
      s1_q.v1 <= tri_min;
      s1_q.v2 <= tri_med;
      s1_q.v3 <= tri_max;
      s1_q.v4 <= (vec_i.v4 < vec_i.v5) ? vec_i.v4 : vec_i.v5;
      s1_q.v5 <= (vec_i.v4 < vec_i.v5) ? vec_i.v5 : vec_i.v4;

      // low ends and high ends exchanged, giving global min and max
      s2_q.v1 <= (s1_q.v1 < s1_q.v4) ? s1_q.v1 : s1_q.v4;
      s2_q.v2 <= (s1_q.v1 < s1_q.v4) ? s1_q.v4 : s1_q.v1;
      s2_q.v3 <= s1_q.v2;
      s2_q.v4 <= (s1_q.v3 < s1_q.v5) ? s1_q.v3 : s1_q.v5;
      s2_q.v5 <= (s1_q.v3 < s1_q.v5) ? s1_q.v5 : s1_q.v3;

      vec_o.v1 <= s2_q.v1;
      vec_o.v2 <= mid_min;
      vec_o.v3 <= mid_med;
      vec_o.v4 <= mid_max;
      vec_o.v5 <= s2_q.v5;

      valid_q <= {valid_q[`SORT5_LAT-2:0], valid_i};
    end
  end

  assign valid_o = valid_q[`SORT5_LAT-1];

endmodule

`default_nettype wire

// File: sort7/sort7_pipe.sv
`timescale 1ns/1ps
`default_nettype none
`include "rank_defs.svh"

module sort7_pipe
  import rank_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  logic     valid_i,
  input  win7_t    win_i,
  output logic     valid_o,
  output sorted7_t sorted_o
);

  vec5_t               sa1_in;
  vec5_t               sa1_out;
  vec5_t               p1_sa1;
  logic                sa1_valid;
  logic                p1_valid;
  pix_t [`SORT5_LAT:0] s6_q;
  pix_t [`SORT5_LAT:0] s7_q;
  pix_t [`SORT5_LAT:0] a1_q;
  pix_t [`SORT5_LAT:0] a2_q;
  vec5_t               sa2_in;
  vec5_t               sa2_out;
  vec5_t               p2_sa2;
  logic                sa2_valid;
  logic                p2_valid;
  pix_t                sn1_min, sn1_med, sn1_max;
  pix_t                p3_sn1_min, p3_sn1_med, p3_sn1_max;
  pix_t                p3_b2, p3_b3, p3_b4, p3_b5;
  logic                p3_valid;
  pix_t                sn2_min, sn2_med, sn2_max;
  pix_t                p4_sn1_min, p4_sn2_min, p4_sn2_med, p4_sn2_max;
  pix_t                p4_b3, p4_b4, p4_b5;
  logic                p4_valid;
  pix_t                sn3_min, sn3_med, sn3_max;

  assign sa1_in = '{v1: win_i.s1, v2: win_i.s2, v3: win_i.s3, v4: win_i.s4, v5: win_i.s5};

  sort5_pipe u_sort5_a (
    .clk     (clk),
    .rst_n   (rst_n),
    .valid_i (valid_i),
    .vec_i   (sa1_in),
    .valid_o (sa1_valid),
    .vec_o   (sa1_out)
  );

  // s6 and s7 wait for the first sort, its two smallest wait for the second
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      p1_sa1   <= '0;
      p1_valid <= 1'b0;
      s6_q     <= '0;
      s7_q     <= '0;
      a1_q     <= '0;
      a2_q     <= '0;
    end else begin
      p1_sa1   <= sa1_out;
      p1_valid <= sa1_valid;
      s6_q     <= {s6_q[`SORT5_LAT-1:0], win_i.s6};
      s7_q     <= {s7_q[`SORT5_LAT-1:0], win_i.s7};
      a1_q     <= {a1_q[`SORT5_LAT-1:0], p1_sa1.v1};
      a2_q     <= {a2_q[`SORT5_LAT-1:0], p1_sa1.v2};
    end
  end

  // top three of the first sort merged with s6 and s7
  assign sa2_in = '{v1: s6_q[`SORT5_LAT], v2: s7_q[`SORT5_LAT],
                    v3: p1_sa1.v3, v4: p1_sa1.v4, v5: p1_sa1.v5};

  sort5_pipe u_sort5_b (
    .clk     (clk),
    .rst_n   (rst_n),
    .valid_i (p1_valid),
    .vec_i   (sa2_in),
    .valid_o (sa2_valid),
    .vec_o   (sa2_out)
  );

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      p2_sa2   <= '0;
      p2_valid <= 1'b0;
    end else begin
      p2_sa2   <= sa2_out;
      p2_valid <= sa2_valid;
    end
  end

  // v3..v5 of the second sort are already the top three of the window
  sort3_net u_sn1 (
    .a_i   (a1_q[`SORT5_LAT]),
    .b_i   (a2_q[`SORT5_LAT]),
    .c_i   (p2_sa2.v1),
    .min_o (sn1_min),
    .med_o (sn1_med),
    .max_o (sn1_max)
  );

  sort3_net u_sn2 (
    .a_i   (p3_sn1_med),
    .b_i   (p3_sn1_max),
    .c_i   (p3_b2),
    .min_o (sn2_min),
    .med_o (sn2_med),
    .max_o (sn2_max)
  );

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      p3_sn1_min <= '0;
      p3_sn1_med <= '0;
      p3_sn1_max <= '0;
      p3_b2      <= '0;
      p3_b3      <= '0;
      p3_b4      <= '0;
      p3_b5      <= '0;
      p3_valid   <= 1'b0;
      p4_sn1_min <= '0;
      p4_sn2_min <= '0;
      p4_sn2_med <= '0;
      p4_sn2_max <= '0;
      p4_b3      <= '0;
      p4_b4      <= '0;
      p4_b5      <= '0;
      p4_valid   <= 1'b0;
    end else begin
      p3_sn1_min <= sn1_min;
      p3_sn1_med <= sn1_med;
      p3_sn1_max <= sn1_max;
      p3_b2      <= p2_sa2.v2;
      p3_b3      <= p2_sa2.v3;
      p3_b4      <= p2_sa2.v4;
      p3_b5      <= p2_sa2.v5;
      p3_valid   <= p2_valid;
      p4_sn1_min <= p3_sn1_min;
      p4_sn2_min <= sn2_min;
      p4_sn2_med <= sn2_med;
      p4_sn2_max <= sn2_max;
      p4_b3      <= p3_b3;
      p4_b4      <= p3_b4;
      p4_b5      <= p3_b5;
      p4_valid   <= p3_valid;
    end
  end

  sort3_net u_sn3 (
    .a_i   (p4_sn1_min),
    .b_i   (p4_sn2_med),
    .c_i   (p4_sn2_min),
    .min_o (sn3_min),
    .med_o (sn3_med),
    .max_o (sn3_max)
  );

  assign sorted_o = '{r1: sn3_min, r2: sn3_med, r3: sn3_max, r4: p4_sn2_max,
                      r5: p4_b3, r6: p4_b4, r7: p4_b5};
  assign valid_o  = p4_valid;

endmodule

`default_nettype wire

// File: src/window_shift.sv
`timescale 1ns/1ps
`default_nettype none

module window_shift
  import rank_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       pix_valid_i,
  input  logic       line_start_i,
  input  pix_t       pix_i,
  input  rank_mode_e mode_i,
  output logic       win_valid_o,
  output win7_t      win_o,
  output rank_mode_e mode_o
);

  logic [2:0] fill_q;
  logic [2:0] fill_nxt;

  // pixels of the current line held after this shift, saturating at seven
  always_comb begin
    if (line_start_i) begin
      fill_nxt = 3'd1;
    end else if (fill_q == 3'd7) begin
      fill_nxt = 3'd7;
    end else begin
      fill_nxt = fill_q + 3'd1;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      fill_q      <= '0;
      win_o       <= '0;
      win_valid_o <= 1'b0;
      mode_o      <= RANK_MIN;
    end else begin
      win_valid_o <= 1'b0;
      if (pix_valid_i) begin
        fill_q      <= fill_nxt;
        win_o.s1    <= win_o.s2;
        win_o.s2    <= win_o.s3;
        win_o.s3    <= win_o.s4;
        win_o.s4    <= win_o.s5;
        win_o.s5    <= win_o.s6;
        win_o.s6    <= win_o.s7;
        win_o.s7    <= pix_i;
        win_valid_o <= (fill_nxt == 3'd7);
        mode_o      <= mode_i;
      end
    end
  end

endmodule

`default_nettype wire

// File: src/rank_select.sv
`timescale 1ns/1ps
`default_nettype none
`include "rank_defs.svh"

module rank_select
  import rank_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       valid_i,
  input  sorted7_t   sorted_i,
  input  rank_mode_e mode_i,
  output logic       rank_valid_o,
  output pix_t       rank_o
);

  rank_mode_e mode_q [`SORT7_LAT];

  // mode follows its window through the sorter
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < `SORT7_LAT; i++) begin
        mode_q[i] <= RANK_MIN;
      end
    end else begin
      mode_q[0] <= mode_i;
      for (int i = 1; i < `SORT7_LAT; i++) begin
        mode_q[i] <= mode_q[i-1];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rank_valid_o <= 1'b0;
      rank_o       <= '0;
    end else begin
      rank_valid_o <= valid_i;
      if (valid_i) begin
        case (mode_q[`SORT7_LAT-1])
          RANK_MIN: rank_o <= sorted_i.r1;
          RANK_MAX: rank_o <= sorted_i.r7;
          default:  rank_o <= sorted_i.r4;
        endcase
      end
    end
  end

endmodule

`default_nettype wire

// File: src/rank_filter_top.sv
`timescale 1ns/1ps
`default_nettype none

module rank_filter_top
  import rank_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       pix_valid_i,
  input  logic       line_start_i,
  input  pix_t       pix_i,
  input  rank_mode_e mode_i,
  output logic       rank_valid_o,
  output pix_t       rank_o
);

  win7_t      win;
  logic       win_valid;
  rank_mode_e win_mode;
  sorted7_t   sorted;
  logic       sorted_valid;

  window_shift u_window (
    .clk          (clk),
    .rst_n        (rst_n),
    .pix_valid_i  (pix_valid_i),
    .line_start_i (line_start_i),
    .pix_i        (pix_i),
    .mode_i       (mode_i),
    .win_valid_o  (win_valid),
    .win_o        (win),
    .mode_o       (win_mode)
  );

  sort7_pipe u_sort7 (
    .clk      (clk),
    .rst_n    (rst_n),
    .valid_i  (win_valid),
    .win_i    (win),
    .valid_o  (sorted_valid),
    .sorted_o (sorted)
  );

  rank_select u_select (
    .clk          (clk),
    .rst_n        (rst_n),
    .valid_i      (sorted_valid),
    .sorted_i     (sorted),
    .mode_i       (win_mode),
    .rank_valid_o (rank_valid_o),
    .rank_o       (rank_o)
  );

endmodule

`default_nettype wire

// File: testbench/tb_rank_filter.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rank_filter
  import rank_pkg::*;
();

  localparam int LATENCY     = 12;
  localparam int RESET_LEN   = 16;
  localparam int STIM_CYCLES = 40 + 30 + 40 + 80 + 100 + 1;
  localparam int TIMEOUT     = RESET_LEN + STIM_CYCLES + LATENCY + 50;

  typedef struct packed {
    logic [31:0] due;
    pix_t        val;
  } expect_t;

  logic             clk;
  logic             rst_n;
  logic             pix_valid;
  logic             line_start;
  pix_t             pix;
  rank_mode_e       mode;
  logic             rank_valid;
  pix_t             rank_pix;
  logic [31:0]      lfsr;
  logic [31:0]      cyc;
  logic [6:0][7:0]  hist;
  int               fill;
  int               val_errs;
  int               miss_errs;
  int               unexp_errs;
  expect_t          exp_q[$];

  rank_filter_top DUT (
    .clk          (clk),
    .rst_n        (rst_n),
    .pix_valid_i  (pix_valid),
    .line_start_i (line_start),
    .pix_i        (pix),
    .mode_i       (mode),
    .rank_valid_o (rank_valid),
    .rank_o       (rank_pix)
  );

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic rand_bits(input int n, output logic [7:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      val  = {val[6:0], lfsr[0]};
    end
  endtask

  function automatic rank_mode_e to_mode(input logic [1:0] b);
    case (b)
      2'd0:    return RANK_MIN;
      2'd2:    return RANK_MAX;
      default: return RANK_MED;
    endcase
  endfunction

  // insertion sort of the window, then the rank asked for
  function automatic pix_t pick_rank(input logic [6:0][7:0] w, input rank_mode_e m);
    pix_t v [0:6];
    pix_t t;
    int   j;
    for (int i = 0; i < 7; i++) begin
      v[i] = w[i];
    end
    for (int i = 1; i < 7; i++) begin
      t = v[i];
      j = i - 1;
      while (j >= 0 && v[j] > t) begin
        v[j+1] = v[j];
        j--;
      end
      v[j+1] = t;
    end
    case (m)
      RANK_MIN: return v[0];
      RANK_MAX: return v[6];
      default:  return v[3];
    endcase
  endfunction

  task automatic drive(input logic v, input logic ls, input pix_t p, input rank_mode_e m);
    @(posedge clk);
    pix_valid  <= v;
    line_start <= ls;
    pix        <= p;
    mode       <= m;
  endtask

  task automatic print_counts();
    $display("errors: %0d mismatches, %0d missing outputs, %0d unexpected outputs",
             val_errs, miss_errs, unexp_errs);
  endtask

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (cyc >= TIMEOUT) begin
      $display("timeout: the run did not finish within %0d cycles", TIMEOUT);
      print_counts();
      $display("Test failed");
      $finish;
    end
  end

  // reference model follows what the DUT samples on this edge
  always @(posedge clk) begin : ref_model
    expect_t item;
    if (!rst_n) begin
      fill = 0;
    end else if (pix_valid) begin
      if (line_start) begin
        fill = 1;
      end else if (fill < 7) begin
        fill++;
      end
      hist = {hist[5:0], pix};
      if (fill == 7) begin
        item.due = cyc + LATENCY;
        item.val = pick_rank(hist, mode);
        exp_q.push_back(item);
      end
    end
  end

  always @(posedge clk) begin : check_out
    expect_t head;
    if (rst_n) begin
      assert (!$isunknown(rank_valid)) else begin
        $display("rank_valid_o is unknown at %0t", $time);
        unexp_errs++;
      end
      if (exp_q.size() > 0) begin
        head = exp_q[0];
        assert (head.due >= cyc) else begin
          $display("no output at %0t for the window due in cycle %0d", $time, head.due);
          miss_errs++;
          void'(exp_q.pop_front());
        end
      end
      if (rank_valid) begin
        assert (exp_q.size() > 0 && exp_q[0].due == cyc) else begin
          $display("unexpected rank_valid_o at %0t in cycle %0d", $time, cyc);
          unexp_errs++;
        end
        if (exp_q.size() > 0 && exp_q[0].due == cyc) begin
          head = exp_q.pop_front();
          assert (rank_pix == head.val) else begin
            $display("Mismatch at %0t: rank_o is %0d, expected %0d",
                     $time, rank_pix, head.val);
            val_errs++;
          end
        end
      end
    end
  end

  initial begin : stimulus
    logic [7:0] p;
    logic [7:0] b;
    logic [7:0] m;
    int         pos;
    int         li;
    int         line_len [0:4];
    rst_n      = 1'b0;
    pix_valid  = 1'b0;
    line_start = 1'b0;
    pix        = '0;
    mode       = RANK_MED;
    lfsr       = 32'd93321;
    cyc        = '0;
    hist       = '0;
    fill       = 0;
    val_errs   = 0;
    miss_errs  = 0;
    unexp_errs = 0;
    line_len   = '{4, 9, 3, 12, 8};
    pos        = 0;
    li         = 0;
    repeat (RESET_LEN) @(posedge clk);
    rst_n <= 1'b1;

    // continuous median over random pixels
    for (int i = 0; i < 40; i++) begin
      rand_bits(8, p);
      drive(1'b1, i == 0, p, RANK_MED);
    end
    // narrow value range forces duplicates
    for (int i = 0; i < 30; i++) begin
      rand_bits(2, b);
      drive(1'b1, 1'b0, 8'd120 + b, RANK_MED);
    end
    // mode changes from window to window
    for (int i = 0; i < 40; i++) begin
      rand_bits(8, p);
      rand_bits(2, m);
      drive(1'b1, 1'b0, p, to_mode(m[1:0]));
    end
    // roughly half the cycles idle
    for (int i = 0; i < 80; i++) begin
      rand_bits(1, b);
      rand_bits(8, p);
      rand_bits(2, m);
      drive(b[0], 1'b0, p, to_mode(m[1:0]));
    end
    // lines of mixed length where some are shorter than a window
    for (int i = 0; i < 100; i++) begin
      rand_bits(2, b);
      rand_bits(8, p);
      rand_bits(2, m);
      if (b[1:0] != 2'd0) begin
        drive(1'b1, pos == 0, p, to_mode(m[1:0]));
        pos++;
        if (pos == line_len[li]) begin
          pos = 0;
          li  = (li + 1) % 5;
        end
      end else begin
        drive(1'b0, 1'b0, p, to_mode(m[1:0]));
      end
    end
    drive(1'b0, 1'b0, '0, RANK_MED);

    while (exp_q.size() != 0) @(posedge clk);
    // a few idle cycles to catch stray outputs
    repeat (20) @(posedge clk);
    print_counts();
    if (val_errs + miss_errs + unexp_errs == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: src.f
+incdir+common
common/rank_pkg.sv
src/sort3_net.sv
sort5/sort5_pipe.sv
sort7/sort7_pipe.sv
src/window_shift.sv
src/rank_select.sv
src/rank_filter_top.sv
testbench/tb_rank_filter.sv

// File: Bender.yml
package:
  name: rank_filter

sources:
  - include_dirs:
      - common
    files:
      - common/rank_pkg.sv
      - src/sort3_net.sv
      - sort5/sort5_pipe.sv
      - sort7/sort7_pipe.sv
      - src/window_shift.sv
      - src/rank_select.sv
      - src/rank_filter_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - testbench/tb_rank_filter.sv
